// File: include/cadr_ucode_cfg.svh
`ifndef CADR_UCODE_CFG_SVH
`define CADR_UCODE_CFG_SVH

// Data path and microinstruction widths.
`define CADR_WORD_W     32
`define CADR_IR_W       49

// Stack depths.
`define CADR_PDL_DEPTH  16
`define CADR_SPC_DEPTH  8

// Host register map, word addresses.
`define CADR_ADDR_IR_LO   3'd0
`define CADR_ADDR_IR_HI   3'd1
`define CADR_ADDR_OB      3'd2
`define CADR_ADDR_CTRL    3'd3
`define CADR_ADDR_RESULT  3'd4
`define CADR_ADDR_STATUS  3'd5

`endif

// File: design/cadr_ucode_pkg.sv
`include "cadr_ucode_cfg.svh"

package cadr_ucode_pkg;

   typedef logic [`CADR_WORD_W-1:0]            word_t;
   typedef logic [`CADR_IR_W-1:0]              ir_t;
   typedef logic [$clog2(`CADR_PDL_DEPTH)-1:0] pdl_ptr_t;
   typedef logic [$clog2(`CADR_SPC_DEPTH)-1:0] spc_ptr_t;

   // Instruction class, funct and special-ALU flags. Also the STATUS layout.
   typedef struct packed {
      logic       op_byte;
      logic       op_disp;
      logic       op_jump;
      logic       op_alu;
      logic [3:0] funct;
      logic       div;
      logic       mul;
   } op_class_t;

   typedef struct packed {
      logic q;
      logic opc;
      logic pdltop;
      logic pdlpop;
      logic pdlidx;
      logic pdlptr;
      logic spc;
      logic dc;
      logic spcpop;
      logic lc;
      logic md;
      logic map;
      logic vma;
   } src_sel_t;

   typedef struct packed {
      logic lc;
      logic intctl;
      logic imod0;
      logic imod1;
      logic spc;
      logic pdlp;
      logic pdlx;
      logic pdl_x;
      logic pdl_p;
      logic pdltop;
      logic vma;
      logic mdr;
      logic qload;
   } dest_sel_t;

   typedef enum logic {
      step_idle,
      step_exec
   } step_state_e;

   typedef struct packed {
      logic     cyc;
      logic     stb;
      logic     we;
      logic [2:0] adr;
      word_t    dat;
   } wb_req_t;

   typedef struct packed {
      logic  ack;
      word_t dat;
   } wb_rsp_t;

endpackage

// File: design/cadr_source_decode.sv
`timescale 1ns/1ps

module cadr_source_decode (
   input  cadr_ucode_pkg::ir_t       ir,
   input  logic                      nop,
   output cadr_ucode_pkg::op_class_t op_class,
   output cadr_ucode_pkg::src_sel_t  src_sel,
   output cadr_ucode_pkg::dest_sel_t dest_sel
);

   import cadr_ucode_pkg::*;

   logic       dest_func;   // Functional destination field valid.
   logic [2:0] src_code;
   logic [2:0] dest_code;

   assign src_code  = ir[28:26];
   assign dest_code = ir[21:19];

   // --------------------------------------------------
   // Class, funct and special ALU
   // --------------------------------------------------
   always_comb begin
      op_class = '0;
      if (!nop) begin
         case (ir[44:43])
            2'b00:   op_class.op_byte = 1'b1;
            2'b01:   op_class.op_disp = 1'b1;
            2'b10:   op_class.op_jump = 1'b1;
            default: op_class.op_alu  = 1'b1;
         endcase
         op_class.funct = 4'b0001 << ir[11:10];
      end
      if (ir[8] && op_class.op_alu) begin
         if (ir[4:3] == 2'b00)
            op_class.mul = 1'b1;
         else
            op_class.div = 1'b1;
      end
   end

   // --------------------------------------------------
   // Functional sources
   // --------------------------------------------------
   always_comb begin
      src_sel = '0;
      if (ir[31]) begin
         if (!ir[29]) begin
            case (src_code)
               3'd0:    src_sel.q      = 1'b1;
               3'd1:    src_sel.opc    = 1'b1;
               3'd2:    src_sel.pdltop = 1'b1;
               3'd3:    src_sel.pdlpop = 1'b1;
               3'd4:    src_sel.pdlidx = 1'b1;
               3'd5:    src_sel.pdlptr = 1'b1;
               3'd6:    src_sel.spc    = 1'b1;
               default: src_sel.dc     = 1'b1;
            endcase
         end else begin
            case (src_code)
               3'd0:    src_sel.spcpop = 1'b1;
               3'd1:    src_sel.lc     = 1'b1;
               3'd2:    src_sel.md     = 1'b1;
               3'd3:    src_sel.map    = 1'b1;
               3'd4:    src_sel.vma    = 1'b1;
               default: src_sel = '0;   // Unused codes.
            endcase
         end
      end
   end

   // --------------------------------------------------
   // Functional destinations
   // --------------------------------------------------
   assign dest_func = (op_class.op_byte | op_class.op_alu) & ~ir[25];

   always_comb begin
      dest_sel = '0;
      if (dest_func) begin
         if (ir[23]) begin
            dest_sel.vma = ~ir[22];
            dest_sel.mdr = ir[22];
         end else if (!ir[22]) begin
            case (dest_code)
               3'd1:    dest_sel.lc     = 1'b1;
               3'd2:    dest_sel.intctl = 1'b1;
               default: dest_sel.lc     = 1'b0;
            endcase
         end else begin
            case (dest_code)
               3'd0:    dest_sel.pdltop = 1'b1;
               3'd1:    dest_sel.pdl_p  = 1'b1;
               3'd2:    dest_sel.pdl_x  = 1'b1;
               3'd3:    dest_sel.pdlx   = 1'b1;
               3'd4:    dest_sel.pdlp   = 1'b1;
               3'd5:    dest_sel.spc    = 1'b1;
               3'd6:    dest_sel.imod0  = 1'b1;
               default: dest_sel.imod1  = 1'b1;
            endcase
         end
      end
      // Q-control 11 on an ALU instruction.
      dest_sel.qload = op_class.op_alu & (ir[1:0] == 2'b11);
   end

endmodule

// File: design/cadr_func_regs.sv
`timescale 1ns/1ps
`include "cadr_ucode_cfg.svh"

module cadr_func_regs (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      step,
   input  cadr_ucode_pkg::word_t     ob,
   input  cadr_ucode_pkg::src_sel_t  src_sel,
   input  cadr_ucode_pkg::dest_sel_t dest_sel,
   output cadr_ucode_pkg::word_t     result,
   output logic                      done
);

   import cadr_ucode_pkg::*;

   step_state_e state;
   logic        exec;

   word_t    q;
   word_t    lc;
   word_t    vma;
   word_t    md;
   word_t    intctl;
   pdl_ptr_t pdl_ptr;
   pdl_ptr_t pdl_idx;
   spc_ptr_t spc_ptr;
   word_t    pdl_mem [`CADR_PDL_DEPTH];
   word_t    spc_mem [`CADR_SPC_DEPTH];

   word_t    src_val;
   pdl_ptr_t pdl_ptr_rd;   // Pointer after a pop.
   pdl_ptr_t pdl_ptr_nx;
   pdl_ptr_t pdl_wa;
   logic     pdl_we;
   spc_ptr_t spc_ptr_rd;
   spc_ptr_t spc_ptr_nx;

   // --------------------------------------------------
   // Step sequencing
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= step_idle;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            step_idle: begin
               if (step)
                  state <= step_exec;
            end
            default: begin
               state <= step_idle;
               done  <= 1'b1;
            end
         endcase
      end
   end

   assign exec = (state == step_exec);

   // Source read from the state before this step's writes.
   always_comb begin
      src_val = '0;
      if (src_sel.q)
         src_val = q;
      else if (src_sel.pdltop || src_sel.pdlpop)
         src_val = pdl_mem[pdl_ptr];
      else if (src_sel.pdlidx)
         src_val = word_t'(pdl_idx);
      else if (src_sel.pdlptr)
         src_val = word_t'(pdl_ptr);
      else if (src_sel.spc || src_sel.spcpop)
         src_val = spc_mem[spc_ptr];
      else if (src_sel.lc)
         src_val = lc;
      else if (src_sel.md)
         src_val = md;
      else if (src_sel.vma)
         src_val = vma;
   end

   // --------------------------------------------------
   // Stack pointer update
   // --------------------------------------------------
   always_comb begin
      pdl_ptr_rd = src_sel.pdlpop ? pdl_ptr - 1'b1 : pdl_ptr;
      pdl_ptr_nx = pdl_ptr_rd;
      pdl_wa     = pdl_ptr_rd;
      pdl_we     = 1'b0;
      if (dest_sel.pdlp) begin
         pdl_ptr_nx = pdl_ptr_t'(ob);
      end else if (dest_sel.pdl_p) begin
         pdl_ptr_nx = pdl_ptr_rd + 1'b1;
         pdl_wa     = pdl_ptr_rd + 1'b1;
         pdl_we     = 1'b1;
      end else if (dest_sel.pdltop) begin
         pdl_we = 1'b1;
      end else if (dest_sel.pdl_x) begin
         pdl_wa = pdl_idx;
         pdl_we = 1'b1;
      end
      spc_ptr_rd = src_sel.spcpop ? spc_ptr - 1'b1 : spc_ptr;
      spc_ptr_nx = dest_sel.spc ? spc_ptr_rd + 1'b1 : spc_ptr_rd;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         result  <= '0;
         q       <= '0;
         lc      <= '0;
         vma     <= '0;
         md      <= '0;
         intctl  <= '0;
         pdl_ptr <= '0;
         pdl_idx <= '0;
         spc_ptr <= '0;
      end else if (exec) begin
         result  <= src_val;
         pdl_ptr <= pdl_ptr_nx;
         spc_ptr <= spc_ptr_nx;
         if (dest_sel.qload) q <= ob;
         if (dest_sel.lc) lc <= ob;
         if (dest_sel.intctl) intctl <= ob;
         if (dest_sel.vma) vma <= ob;
         if (dest_sel.mdr) md <= ob;
         if (dest_sel.pdlx) pdl_idx <= pdl_ptr_t'(ob);
      end
   end

   // Stack storage.
   always_ff @(posedge clk) begin
      if (exec && pdl_we)
         pdl_mem[pdl_wa] <= ob;
      if (exec && dest_sel.spc)
         spc_mem[spc_ptr_nx] <= ob;   // Push lands above the old top.
   end

endmodule

// File: design/cadr_host_port.sv
`timescale 1ns/1ps
`include "cadr_ucode_cfg.svh"

module cadr_host_port (
   input  logic                      clk,
   input  logic                      rst_n,
   input  cadr_ucode_pkg::wb_req_t   wb_req,
   output cadr_ucode_pkg::wb_rsp_t   wb_rsp,
   output cadr_ucode_pkg::ir_t       ir,
   output cadr_ucode_pkg::word_t     ob,
   output logic                      nop,
   output logic                      step,
   input  cadr_ucode_pkg::op_class_t op_class,
   input  cadr_ucode_pkg::word_t     result,
   input  logic                      done
);

   import cadr_ucode_pkg::*;

   logic      ack;
   logic      bus_wr;
   logic      start;
   logic      busy;
   op_class_t status_class;
   word_t     rd_data;

   // --------------------------------------------------
   // Wishbone handshake
   // --------------------------------------------------
   // One-cycle ack, then one idle cycle before the next.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         ack <= 1'b0;
      else
         ack <= wb_req.cyc & wb_req.stb & ~ack;
   end

   assign bus_wr = ack & wb_req.cyc & wb_req.stb & wb_req.we;
   assign start  = bus_wr & (wb_req.adr == `CADR_ADDR_CTRL) & wb_req.dat[0] & ~busy;

   // Host-visible registers.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ir  <= '0;
         ob  <= '0;
         nop <= 1'b0;
      end else if (bus_wr) begin
         case (wb_req.adr)
            `CADR_ADDR_IR_LO: ir[`CADR_WORD_W-1:0] <= wb_req.dat;
            `CADR_ADDR_IR_HI: begin
               ir[`CADR_IR_W-1:`CADR_WORD_W] <= wb_req.dat[`CADR_IR_W-`CADR_WORD_W-1:0];
            end
            `CADR_ADDR_OB:    ob <= wb_req.dat;
            `CADR_ADDR_CTRL: begin
               if (start)
                  nop <= wb_req.dat[1];   // Latched per step.
            end
            default: ;
         endcase
      end
   end

   // --------------------------------------------------
   // Step control and status
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         step         <= 1'b0;
         busy         <= 1'b0;
         status_class <= '0;
      end else begin
         step <= start;
         if (start)
            busy <= 1'b1;
         else if (done)
            busy <= 1'b0;
         if (done)
            status_class <= op_class;
      end
   end

   // Readback mux, valid with ack.
   always_comb begin
      case (wb_req.adr)
         `CADR_ADDR_IR_LO:  rd_data = ir[`CADR_WORD_W-1:0];
         `CADR_ADDR_IR_HI:  rd_data = word_t'(ir[`CADR_IR_W-1:`CADR_WORD_W]);
         `CADR_ADDR_OB:     rd_data = ob;
         `CADR_ADDR_RESULT: rd_data = result;
         `CADR_ADDR_STATUS: begin
            rd_data = {busy, {(`CADR_WORD_W-1-$bits(op_class_t)){1'b0}}, status_class};
         end
         default:           rd_data = '0;   // CTRL is write only.
      endcase
   end

   assign wb_rsp.ack = ack;
   assign wb_rsp.dat = rd_data;

endmodule

// File: design/cadr_ucode_top.sv
`timescale 1ns/1ps

module cadr_ucode_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  cadr_ucode_pkg::wb_req_t wb_req,
   output cadr_ucode_pkg::wb_rsp_t wb_rsp
);

   import cadr_ucode_pkg::*;

   ir_t       ir;
   word_t     ob;
   word_t     result;
   logic      nop;
   logic      step;
   logic      done;
   op_class_t op_class;
   src_sel_t  src_sel;
   dest_sel_t dest_sel;

   cadr_host_port host_port_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_req   (wb_req),
      .wb_rsp   (wb_rsp),
      .ir       (ir),
      .ob       (ob),
      .nop      (nop),
      .step     (step),
      .op_class (op_class),
      .result   (result),
      .done     (done)
   );

   cadr_source_decode decode_i (
      .ir       (ir),
      .nop      (nop),
      .op_class (op_class),
      .src_sel  (src_sel),
      .dest_sel (dest_sel)
   );

   cadr_func_regs func_regs_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .step     (step),
      .ob       (ob),
      .src_sel  (src_sel),
      .dest_sel (dest_sel),
      .result   (result),
      .done     (done)
   );

endmodule

// File: dv/cadr_clk_gen.sv
`timescale 1ns/1ps

module cadr_clk_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period.
   end

   // Reset held for 10 cycles.
   initial begin
      rst_n = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

endmodule

// File: dv/cadr_ucode_assertions.sv
`timescale 1ns/1ps

module cadr_ucode_assertions (
   input logic                      clk,
   input logic                      rst_n,
   input cadr_ucode_pkg::wb_req_t   wb_req,
   input cadr_ucode_pkg::wb_rsp_t   wb_rsp,
   input cadr_ucode_pkg::op_class_t op_class,
   input cadr_ucode_pkg::src_sel_t  src_sel,
   input cadr_ucode_pkg::dest_sel_t dest_sel
);

   import cadr_ucode_pkg::*;

   int         fail_count = 0;   // Failed assertions so far.
   logic [3:0] class_bits;
   logic [7:0] src_grp;   // First source group.
   logic [7:0] pdl_grp;

   assign class_bits = {op_class.op_byte, op_class.op_disp, op_class.op_jump, op_class.op_alu};
   assign src_grp    = {src_sel.q, src_sel.opc, src_sel.pdltop, src_sel.pdlpop,
                        src_sel.pdlidx, src_sel.pdlptr, src_sel.spc, src_sel.dc};
   assign pdl_grp    = {dest_sel.pdltop, dest_sel.pdl_p, dest_sel.pdl_x, dest_sel.pdlx,
                        dest_sel.pdlp, dest_sel.spc, dest_sel.imod0, dest_sel.imod1};

   // --------------------------------------------------
   // Bus protocol
   // --------------------------------------------------
   ack_single: assert property (@(posedge clk) disable iff (!rst_n)
      wb_rsp.ack |=> !wb_rsp.ack)
      else begin
         fail_count++;
         $error("ack stayed high for more than one cycle");
      end

   ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
      else begin
         fail_count++;
         $error("ack raised without cyc and stb");
      end

   // Decoder select groups.
   class_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(class_bits))
      else begin
         fail_count++;
         $error("instruction class is not one-hot");
      end

   src_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(src_grp))
      else begin
         fail_count++;
         $error("source group selects more than one source");
      end

   pdl_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(pdl_grp))
      else begin
         fail_count++;
         $error("PDL destination group selects more than one destination");
      end

endmodule

// File: dv/cadr_ucode_tb.sv
`timescale 1ns/1ps
`include "cadr_ucode_cfg.svh"

module cadr_ucode_tb;

   import cadr_ucode_pkg::*;

   localparam logic [1:0] cls_byte = 2'd0;
   localparam logic [1:0] cls_disp = 2'd1;
   localparam logic [1:0] cls_jump = 2'd2;
   localparam logic [1:0] cls_alu  = 2'd3;
   // Source codes as {enable, bit 29, bits 28:26}.
   localparam logic [4:0] s_none   = 5'b00000;
   localparam logic [4:0] s_q      = 5'b10000;
   localparam logic [4:0] s_opc    = 5'b10001;
   localparam logic [4:0] s_pdltop = 5'b10010;
   localparam logic [4:0] s_pdlpop = 5'b10011;
   localparam logic [4:0] s_pdlidx = 5'b10100;
   localparam logic [4:0] s_pdlptr = 5'b10101;
   localparam logic [4:0] s_spc    = 5'b10110;
   localparam logic [4:0] s_dc     = 5'b10111;
   localparam logic [4:0] s_spcpop = 5'b11000;
   localparam logic [4:0] s_lc     = 5'b11001;
   localparam logic [4:0] s_md     = 5'b11010;
   localparam logic [4:0] s_map    = 5'b11011;
   localparam logic [4:0] s_vma    = 5'b11100;
   // Destination fields in ir bits 25:19.
   localparam logic [6:0] d_none   = 7'b1000000;
   localparam logic [6:0] d_lc     = 7'b0000001;
   localparam logic [6:0] d_intctl = 7'b0000010;
   localparam logic [6:0] d_unused = 7'b0000011;
   localparam logic [6:0] d_vma    = 7'b0010000;
   localparam logic [6:0] d_md     = 7'b0011000;
   localparam logic [6:0] d_pdltop = 7'b0001000;
   localparam logic [6:0] d_pdl_p  = 7'b0001001;
   localparam logic [6:0] d_pdl_x  = 7'b0001010;
   localparam logic [6:0] d_pdlx   = 7'b0001011;
   localparam logic [6:0] d_pdlp   = 7'b0001100;
   localparam logic [6:0] d_spc    = 7'b0001101;

   logic    clk;
   logic    rst_n;
   wb_req_t wb_req;
   wb_rsp_t wb_rsp;

   int          error_count = 0;
   int          check_count = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          steps_issued = 0;
   int          assert_fails;
   int unsigned seed_val;
   int unsigned cycles;

   // Reference model state.
   word_t    m_q;
   word_t    m_lc;
   word_t    m_vma;
   word_t    m_md;
   word_t    m_intctl;
   pdl_ptr_t m_ptr;
   pdl_ptr_t m_idx;
   spc_ptr_t m_sptr;
   word_t    m_pdl [`CADR_PDL_DEPTH];
   word_t    m_spc [`CADR_SPC_DEPTH];

   cadr_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

   cadr_ucode_top cadr_ucode_top_i (.clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp));

   bind cadr_ucode_top cadr_ucode_assertions assertions_i (
      .clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
      .op_class(op_class), .src_sel(src_sel), .dest_sel(dest_sel)
   );

   // --------------------------------------------------
   // Checks and bus tasks
   // --------------------------------------------------
   task automatic check_word(input string name, input word_t got, input word_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_class(input string name, input op_class_t got, input op_class_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Fail t=%0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic wb_xfer(input logic we, input logic [2:0] adr, input word_t wdat,
                          output word_t rdat);
      int waited;
      @(posedge clk);
      #1;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!wb_rsp.ack && waited < 16);
      rdat = wb_rsp.dat;
      if (!wb_rsp.ack) begin
         error_count++;
         $display("Error at t=%0t: no bus ack for address %0d", $time, adr);
      end
      @(posedge clk);
      #1;
      wb_req = '0;
   endtask

   task automatic wb_write(input logic [2:0] adr, input word_t dat);
      word_t unused;
      wb_xfer(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input logic [2:0] adr, output word_t dat);
      wb_xfer(1'b0, adr, '0, dat);
   endtask

   function automatic ir_t build_ir(input logic [1:0] cls, input logic [4:0] src,
                                    input logic [6:0] dst, input logic [1:0] qc);
      ir_t ir;
      ir = '0;
      ir[44:43] = cls;
      ir[31]    = src[4];
      ir[29]    = src[3];
      ir[28:26] = src[2:0];
      ir[25:19] = dst;
      ir[1:0]   = qc;
      return ir;
   endfunction

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------
   task automatic model_step(input ir_t ir, input word_t ob, input logic nop,
                             output word_t res, output op_class_t cls);
      logic [2:0] code;
      cls  = '0;
      res  = '0;
      code = ir[21:19];
      if (!nop) begin
         cls.op_byte = (ir[44:43] == 2'd0);
         cls.op_disp = (ir[44:43] == 2'd1);
         cls.op_jump = (ir[44:43] == 2'd2);
         cls.op_alu  = (ir[44:43] == 2'd3);
         cls.funct[ir[11:10]] = 1'b1;
         cls.mul = cls.op_alu && ir[8] && (ir[4:3] == 2'b00);
         cls.div = cls.op_alu && ir[8] && (ir[4:3] != 2'b00);
      end
      // Read before a pop moves the pointer.
      if (ir[31]) begin
         case ({ir[29], ir[28:26]})
            4'd0:    res = m_q;
            4'd2:    res = m_pdl[m_ptr];
            4'd3: begin
               res   = m_pdl[m_ptr];
               m_ptr = m_ptr - 1'b1;
            end
            4'd4:    res = word_t'(m_idx);
            4'd5:    res = word_t'(m_ptr);
            4'd6:    res = m_spc[m_sptr];
            4'd8: begin
               res    = m_spc[m_sptr];
               m_sptr = m_sptr - 1'b1;
            end
            4'd9:    res = m_lc;
            4'd10:   res = m_md;
            4'd12:   res = m_vma;
            default: res = '0;
         endcase
      end
      if ((cls.op_byte || cls.op_alu) && !ir[25]) begin
         if (ir[23] && ir[22])
            m_md = ob;
         else if (ir[23])
            m_vma = ob;
         else if (!ir[22] && code == 3'd1)
            m_lc = ob;
         else if (!ir[22] && code == 3'd2)
            m_intctl = ob;
         else if (ir[22]) begin
            case (code)
               3'd0: m_pdl[m_ptr] = ob;
               3'd1: begin
                  m_ptr = m_ptr + 1'b1;
                  m_pdl[m_ptr] = ob;
               end
               3'd2: m_pdl[m_idx] = ob;
               3'd3: m_idx = pdl_ptr_t'(ob);
               3'd4: m_ptr = pdl_ptr_t'(ob);
               3'd5: begin
                  m_sptr = m_sptr + 1'b1;
                  m_spc[m_sptr] = ob;
               end
               default: ;   // imod has no effect.
            endcase
         end
      end
      if (cls.op_alu && ir[1:0] == 2'b11)
         m_q = ob;
   endtask

   // --------------------------------------------------
   // Step sequencing
   // --------------------------------------------------
   task automatic load_and_start(input ir_t ir, input word_t ob, input logic nop);
      wb_write(`CADR_ADDR_IR_LO, ir[31:0]);
      wb_write(`CADR_ADDR_IR_HI, word_t'(ir[48:32]));
      wb_write(`CADR_ADDR_OB, ob);
      wb_write(`CADR_ADDR_CTRL, {30'd0, nop, 1'b1});
   endtask

   task automatic check_outcome(input word_t exp_res, input op_class_t exp_cls);
      word_t st;
      word_t res;
      int    polls;
      polls = 0;
      do begin
         wb_read(`CADR_ADDR_STATUS, st);
         polls++;
      end while (st[31] && polls < 20);
      if (st[31]) begin
         error_count++;
         $display("Error at t=%0t: step never finished, busy stayed set", $time);
      end
      wb_read(`CADR_ADDR_RESULT, res);
      check_word("result", res, exp_res);
      check_class("status_class", op_class_t'(st[9:0]), exp_cls);
   endtask

   task automatic run_step(input ir_t ir, input word_t ob, input logic nop);
      word_t     exp_res;
      op_class_t exp_cls;
      steps_issued++;
      model_step(ir, ob, nop, exp_res, exp_cls);
      load_and_start(ir, ob, nop);
      check_outcome(exp_res, exp_cls);
   endtask

   task automatic finish_test(input string name, input int errs_before);
      tests_run++;
      if (error_count == errs_before)
         $display("test %-12s ok", name);
      else begin
         tests_failed++;
         $display("test %-12s failed with %0d errors", name, error_count - errs_before);
      end
   endtask

   // --------------------------------------------------
   // Directed tests
   // --------------------------------------------------
   task automatic test_class();
      ir_t ir;
      int  errs;
      errs = error_count;
      for (int c = 0; c < 4; c++) begin
         for (int f = 0; f < 4; f++) begin
            ir = build_ir(2'(c), s_none, d_none, 2'b00);
            ir[11:10] = 2'(f);
            run_step(ir, $urandom, 1'b0);
         end
      end
      ir = build_ir(cls_alu, s_none, d_none, 2'b00);
      ir[8] = 1'b1;
      run_step(ir, $urandom, 1'b0);   // Multiply.
      ir[4:3] = 2'b10;
      run_step(ir, $urandom, 1'b0);   // Divide.
      ir[44:43] = cls_byte;
      run_step(ir, $urandom, 1'b0);
      run_step(build_ir(cls_alu, s_none, d_lc, 2'b11), $urandom, 1'b1);
      finish_test("class", errs);
   endtask

   task automatic test_regs();
      int errs;
      errs = error_count;
      run_step(build_ir(cls_byte, s_none, d_lc, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_jump, s_lc, d_none, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_alu, s_none, d_vma, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_jump, s_vma, d_none, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_byte, s_none, d_md, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_jump, s_md, d_none, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_byte, s_lc, d_lc, 2'b00), $urandom, 1'b0);   // Old value out.
      run_step(build_ir(cls_byte, s_none, d_intctl, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_jump, s_lc, d_none, 2'b00), $urandom, 1'b0);
      finish_test("registers", errs);
   endtask

   task automatic test_pdl();
      word_t idx;
      int    errs;
      errs = error_count;
      idx  = $urandom;
      repeat (3) run_step(build_ir(cls_byte, s_none, d_pdl_p, 2'b00), $urandom, 1'b0);
      repeat (3) run_step(build_ir(cls_jump, s_pdlpop, d_none, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_byte, s_none, d_pdlx, 2'b00), idx, 1'b0);
      run_step(build_ir(cls_byte, s_pdlidx, d_pdl_x, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_byte, s_pdlptr, d_pdlp, 2'b00), idx, 1'b0);
      run_step(build_ir(cls_jump, s_pdltop, d_none, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_alu, s_pdltop, d_pdltop, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_jump, s_pdltop, d_none, 2'b00), $urandom, 1'b0);
      finish_test("pdl", errs);
   endtask

   task automatic test_spc();
      int errs;
      errs = error_count;
      repeat (3) run_step(build_ir(cls_byte, s_none, d_spc, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_jump, s_spc, d_none, 2'b00), $urandom, 1'b0);
      repeat (3) run_step(build_ir(cls_jump, s_spcpop, d_none, 2'b00), $urandom, 1'b0);
      // Ten pushes wrap the 8-entry stack.
      repeat (10) run_step(build_ir(cls_alu, s_none, d_spc, 2'b00), $urandom, 1'b0);
      repeat (8) run_step(build_ir(cls_jump, s_spcpop, d_none, 2'b00), $urandom, 1'b0);
      finish_test("spc", errs);
   endtask

   task automatic test_no_effect();
      int errs;
      errs = error_count;
      run_step(build_ir(cls_alu, s_none, d_none, 2'b11), $urandom, 1'b0);
      run_step(build_ir(cls_jump, s_q, d_none, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_alu, s_none, d_none, 2'b01), $urandom, 1'b0);
      run_step(build_ir(cls_alu, s_q, d_none, 2'b10), $urandom, 1'b0);
      run_step(build_ir(cls_byte, s_none, d_lc | d_none, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_alu, s_none, d_vma | d_none, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_byte, s_none, d_unused, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_disp, s_none, d_md, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_jump, s_lc, d_none, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_jump, s_vma, d_none, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_jump, s_md, d_none, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_jump, s_opc, d_none, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_jump, s_dc, d_none, 2'b00), $urandom, 1'b0);
      run_step(build_ir(cls_jump, s_map, d_none, 2'b00), $urandom, 1'b0);
      finish_test("no_effect", errs);
   endtask

   task automatic test_busy();
      ir_t       ir;
      word_t     ob;
      word_t     rd;
      word_t     exp_res;
      op_class_t exp_cls;
      int        errs;
      errs = error_count;
      ir = build_ir(cls_byte, s_pdlptr, d_pdl_p, 2'b00);
      ir[48:45] = 4'b1011;
      ob = $urandom;
      steps_issued++;
      model_step(ir, ob, 1'b0, exp_res, exp_cls);
      load_and_start(ir, ob, 1'b0);
      wb_write(`CADR_ADDR_CTRL, 32'd1);   // Lands while busy.
      check_outcome(exp_res, exp_cls);
      wb_read(`CADR_ADDR_IR_LO, rd);
      check_word("ir_lo", rd, ir[31:0]);
      wb_read(`CADR_ADDR_IR_HI, rd);
      check_word("ir_hi", rd, word_t'(ir[48:32]));
      wb_read(`CADR_ADDR_OB, rd);
      check_word("ob", rd, ob);
      run_step(build_ir(cls_jump, s_pdlptr, d_none, 2'b00), $urandom, 1'b0);
      finish_test("busy", errs);
   endtask

   // --------------------------------------------------
   // Main sequence and watchdog
   // --------------------------------------------------
   initial begin
      wb_req   = '0;
      seed_val = $urandom(32'h4968d9d8);
      {m_q, m_lc, m_vma, m_md, m_intctl} = '0;
      {m_ptr, m_idx, m_sptr} = '0;
      foreach (m_pdl[i]) m_pdl[i] = '0;
      foreach (m_spc[i]) m_spc[i] = '0;
      wait (rst_n === 1'b1);
      repeat (2) @(posedge clk);
      test_class();
      test_regs();
      test_pdl();
      test_spc();
      test_no_effect();
      test_busy();
      assert_fails = cadr_ucode_top_i.assertions_i.fail_count;
      $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
               tests_run, tests_failed, check_count, error_count, assert_fails);
      if (error_count == 0 && assert_fails == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

   // Budget of 200 cycles per issued step.
   initial begin
      cycles = 0;
      while (cycles <= 200 * steps_issued + 2000) begin
         @(posedge clk);
         cycles++;
      end
      $display("Watchdog expired after %0d cycles with %0d steps issued", cycles, steps_issued);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: cadr_ucode.f
+incdir+include
design/cadr_ucode_pkg.sv
design/cadr_source_decode.sv
design/cadr_func_regs.sv
design/cadr_host_port.sv
design/cadr_ucode_top.sv
dv/cadr_clk_gen.sv
dv/cadr_ucode_assertions.sv
dv/cadr_ucode_tb.sv
